// ==== mini_dma.f ====
verilog/dma_cfg_pkg.sv
verilog/dma_burst_pkg.sv
verilog/dma_frontend.sv
verilog/dma_backend.sv
verilog/spm_bank.sv
verilog/mini_dma_top.sv
verif/tb_mini_dma.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mini_dma testbench with Verilator.
# Run from the project root. Exits non-zero unless the pass message is printed.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f mini_dma.f --top-module tb_mini_dma \
    --Mdir obj_dir -o sim_mini_dma; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_mini_dma)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1

// ==== verif/mini_dma_vectors.txt ====
# W addr data [sel] = bus write | R addr expected = read and compare
# L id = launch, check id | P = poll DONE | N name = test name (all hex)
N regs
R 00001010 00000001
R 00001014 00000000
W 00001000 00000040
W 00001004 00000080
W 00001008 0000000B
R 00001000 00000040
R 00001004 00000080
R 00001008 0000000B
N spm
W 00000040 11223344
W 00000044 55667788
W 00000048 99AABBCC
W 0000004C DEADBEEF
W 00000088 CAFEF00D
W 00000048 00000012 1
R 00000048 99AABB12
W 0000004C 5A5A0000 C
R 0000004C 5A5ABEEF
N copy
L 0
P
R 00000080 11223344
R 00000084 55667788
R 00000088 CAFEF00D
R 00001014 00000001
N zero
W 00001004 00000088
W 00001008 00000000
L 1
P
R 00000088 CAFEF00D
N long
W 00001004 00000200
W 00001008 00000080
L 2
R 00001014 00000000
R 00001010 00000000
N backpressure
W 00000308 0BADF00D
W 00001004 00000300
W 00001008 00000008
L 3
P
R 00000300 11223344
R 00000304 55667788
R 00000308 0BADF00D
R 00000200 11223344
R 00000204 55667788
R 00000208 99AABB12
R 0000020C 5A5ABEEF

// ==== verif/tb_mini_dma.sv ====
/*
  Testbench for mini_dma_top. Replays the operations of the vectors
  file over the host Wishbone port and checks read data and launch ids.
*/
`timescale 1ns/100ps

module tb_mini_dma;

  import dma_cfg_pkg::*;

  localparam int unsigned SpmWords  = 256;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned ClkPeriod = 20;
  // stall limit in cycles for one bus access covering a full back-pressure wait
  localparam int unsigned BusLimit  = 2000;
  localparam string       VecFile   = "verif/mini_dma_vectors.txt";

  logic    clk;
  logic    rst_n;
  wb_req_t host_req;
  wb_rsp_t host_rsp;

  string       lines[$];
  string       test_name;
  logic [31:0] rnd_state;
  logic [31:0] num_bytes_cur;
  int unsigned data_errs;
  int unsigned id_errs;
  int unsigned other_errs;
  longint      wd_ns;

  mini_dma_top #(
    .SpmWords(SpmWords),
    .IdWidth (IdWidth)
  ) i_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .host_req_i(host_req),
    .host_rsp_o(host_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // xorshift32 step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_data(input logic [BusDw-1:0] exp, input logic [BusDw-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %08h, got %08h", test_name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_id(input logic [IdWidth-1:0] exp, input logic [IdWidth-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected id %0h, got id %0h", test_name, exp, act);
      id_errs++;
    end
  endtask

  // one classic cycle held until ack and then 0 to 3 idle cycles
  task automatic bus_access(input logic we, input logic [BusAw-1:0] adr,
                            input logic [BusDw-1:0] dat, input logic [3:0] sel,
                            output logic [BusDw-1:0] rdata);
    int unsigned waited;
    waited = 0;
    rdata = '0;
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = dat;
    host_req.sel = sel;
    forever begin
      @(negedge clk);
      if (host_rsp.ack) begin
        rdata = host_rsp.dat;
        break;
      end
      waited++;
      if (waited > BusLimit) begin
        $display("bus access to %08h got no ack in %0d cycles", adr, BusLimit);
        other_errs++;
        break;
      end
    end
    host_req = '0;
    rnd_state = xorshift(rnd_state);
    repeat (rnd_state[1:0]) @(negedge clk);
  endtask

  // poll DONE for up to 2 cycles per word plus margin
  task automatic poll_done();
    logic [BusDw-1:0] rd;
    longint           limit_ns;
    longint           t0;
    limit_ns = (longint'(num_bytes_cur / 4) * 2 + 40) * longint'(ClkPeriod);
    t0 = $time;
    forever begin
      bus_access(1'b0, RegBase + 32'h14, '0, 4'hF, rd);
      if (rd[0] === 1'b1) break;
      if ($time - t0 > limit_ns) begin
        $display("%s: DONE still not set after %0d ns", test_name, limit_ns);
        other_errs++;
        break;
      end
    end
  endtask

  task automatic run_line(input string line);
    string            op;
    string            name;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [31:0]      s;
    logic [BusDw-1:0] rd;
    int               n;
    n = $sscanf(line, "%s", op);
    case (op)
      "W": begin
        s = 32'hF;
        n = $sscanf(line, "%s %h %h %h", op, a, d, s);
        if (a == RegBase + 32'h8) num_bytes_cur = d;
        bus_access(1'b1, a, d, s[3:0], rd);
      end
      "R": begin
        n = $sscanf(line, "%s %h %h", op, a, d);
        bus_access(1'b0, a, '0, 4'hF, rd);
        check_data(d, rd);
      end
      "L": begin
        n = $sscanf(line, "%s %h", op, d);
        bus_access(1'b0, RegBase + 32'hC, '0, 4'hF, rd);
        check_id(d[IdWidth-1:0], rd[IdWidth-1:0]);
      end
      "P": poll_done();
      "N": begin
        n = $sscanf(line, "%s %s", op, name);
        test_name = name;
      end
      default: begin
        $display("unknown operation in vectors file: %s", line);
        other_errs++;
      end
    endcase
  endtask

  // watchdog armed once the vectors are loaded
  initial begin
    wait (wd_ns != 0);
    #(wd_ns);
    $display("watchdog: run did not finish within %0d ns", wd_ns);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] max_bytes;
    host_req      = '0;
    rst_n         = 1'b0;
    rnd_state     = 32'd25717;
    num_bytes_cur = '0;
    data_errs     = 0;
    id_errs       = 0;
    other_errs    = 0;
    wd_ns         = 0;
    test_name     = "none";
    max_bytes     = '0;
    fd = $fopen(VecFile, "r");
    if (fd == 0) begin
      $display("cannot open %s", VecFile);
      $display("Test failures found");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // skip comments and blank lines
        if (line.len() < 2 || line.getc(0) == "#") continue;
        lines.push_back(line);
        n = $sscanf(line, "%s %h %h", op, a, d);
        if (op == "W" && a == RegBase + 32'h8 && d > max_bytes) max_bytes = d;
      end
      $fclose(fd);
      wd_ns = longint'(lines.size()) * 600
            + longint'(max_bytes / 4) * 2 * longint'(ClkPeriod);
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      foreach (lines[i]) run_line(lines[i]);
      $display("errors: %0d data, %0d id, %0d other", data_errs, id_errs, other_errs);
      if (data_errs + id_errs + other_errs == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

// ==== verilog/dma_backend.sv ====
/*
  Copy engine of the DMA. Takes one request at a time and copies whole
  32-bit words inside the scratchpad, one read and one write per word,
  through the engine port of the scratchpad bank.
*/
`timescale 1ns/100ps

module dma_backend #(
  parameter int unsigned SpmWords = 256
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  dma_burst_pkg::burst_req_t   burst_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output logic                        idle_o,
  output logic                        complete_o,
  output logic [$clog2(SpmWords)-1:0] spm_addr_o,
  output logic                        spm_we_o,
  output logic [dma_cfg_pkg::BusDw-1:0] spm_wdata_o,
  input  logic [dma_cfg_pkg::BusDw-1:0] spm_rdata_i
);

  import dma_cfg_pkg::*;
  import dma_burst_pkg::*;

  localparam int unsigned Aw = $clog2(SpmWords);
  // word count width is num_bytes without the byte offset bits
  localparam int unsigned Cw = BusDw - 2;

  be_state_e state_q;
  be_state_e state_d;

  logic [Aw-1:0] src_idx_q;
  logic [Aw-1:0] dst_idx_q;
  logic [Cw-1:0] words_q;

  logic          accept;
  logic [Cw-1:0] req_words;
  logic [Aw-1:0] req_src_idx;
  logic [Aw-1:0] req_dst_idx;

  assign accept = valid_i && ready_o;

  // trailing bytes past the last whole word are dropped
  assign req_words = burst_i.num_bytes[BusDw-1:2];

  // byte address to word index wrapped into the scratchpad
  assign req_src_idx = Aw'((burst_i.src >> 2) % SpmWords);
  assign req_dst_idx = Aw'((burst_i.dst >> 2) % SpmWords);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      BE_IDLE: begin
        if (valid_i) begin
          // zero words goes straight to the completion pulse
          state_d = (req_words == '0) ? BE_DONE : BE_READ;
        end
      end
      BE_READ:  state_d = BE_WRITE;
      BE_WRITE: state_d = (words_q == Cw'(1)) ? BE_DONE : BE_READ;
      BE_DONE:  state_d = BE_IDLE;
      default:  state_d = BE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= BE_IDLE;
      src_idx_q <= '0;
      dst_idx_q <= '0;
      words_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        src_idx_q <= req_src_idx;
        dst_idx_q <= req_dst_idx;
        words_q   <= req_words;
      end else if (state_q == BE_WRITE) begin
        // both indices advance after each word and wrap at the top
        src_idx_q <= (src_idx_q == Aw'(SpmWords - 1)) ? '0 : src_idx_q + 1'b1;
        dst_idx_q <= (dst_idx_q == Aw'(SpmWords - 1)) ? '0 : dst_idx_q + 1'b1;
        words_q   <= words_q - 1'b1;
      end
    end
  end

  // source read data arrives one cycle later in BE_WRITE
  always_comb begin
    spm_addr_o  = src_idx_q;
    spm_we_o    = 1'b0;
    spm_wdata_o = spm_rdata_i;
    if (state_q == BE_WRITE) begin
      spm_addr_o = dst_idx_q;
      spm_we_o   = 1'b1;
    end
  end

  // one request at a time
  assign ready_o    = (state_q == BE_IDLE);
  assign idle_o     = (state_q == BE_IDLE);
  assign complete_o = (state_q == BE_DONE);

endmodule

// ==== verilog/dma_burst_pkg.sv ====
/*
  Transfer descriptor handed from the frontend to the copy engine,
  and the state encoding of the copy engine FSM.
*/
package dma_burst_pkg;

  // id field sized for the largest allowed IdWidth
  localparam int unsigned MaxIdWidth = 8;

  // one transfer request
  // num_bytes of zero is discarded by the backend
  typedef struct packed {
    logic [MaxIdWidth-1:0]         id;
    logic [dma_cfg_pkg::BusAw-1:0] src;
    logic [dma_cfg_pkg::BusAw-1:0] dst;
    logic [dma_cfg_pkg::BusDw-1:0] num_bytes;
  } burst_req_t;

  // backend copy FSM states
  typedef enum logic [1:0] {
    // waiting for a request, ready only here
    BE_IDLE,
    // source word address on the scratchpad port
    BE_READ,
    // source word back, written to destination
    BE_WRITE,
    // one cycle completion pulse
    BE_DONE
  } be_state_e;

endpackage

// ==== verilog/dma_cfg_pkg.sv ====
/*
  Host bus definitions for mini_dma: bus widths, Wishbone classic
  request and response structs and the register map of the frontend.
  Imported by every block that sits on the host bus.
*/
package dma_cfg_pkg;

  // host bus widths
  localparam int unsigned BusAw = 32;
  localparam int unsigned BusDw = 32;

  // start of the register block, scratchpad lives below it
  localparam logic [BusAw-1:0] RegBase = 32'h0000_1000;

  // wishbone classic request, held by the master until ack
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [BusAw-1:0] adr;
    logic [BusDw-1:0] dat;
    logic [BusDw/8-1:0] sel;
  } wb_req_t;

  // wishbone response, dat only valid together with ack
  typedef struct packed {
    logic             ack;
    logic [BusDw-1:0] dat;
  } wb_rsp_t;

  // register byte offsets inside the register block
  typedef enum logic [7:0] {
    SRC_ADDR  = 8'h00,
    DST_ADDR  = 8'h04,
    NUM_BYTES = 8'h08,
    NEXT_ID   = 8'h0C,
    STATUS    = 8'h10,
    DONE      = 8'h14
  } reg_addr_e;

endpackage

// ==== verilog/dma_frontend.sv ====
/*
  Register slave of the DMA on the host Wishbone bus. Holds the
  transfer descriptor, launches a transfer on a read of NEXT_ID and
  stalls that read until the backend takes the request.
*/
`timescale 1ns/100ps

module dma_frontend #(
  parameter int unsigned IdWidth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dma_cfg_pkg::wb_req_t      wb_req_i,
  output dma_cfg_pkg::wb_rsp_t      wb_rsp_o,
  output dma_burst_pkg::burst_req_t burst_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  input  logic                      idle_i,
  input  logic                      complete_i
);

  import dma_cfg_pkg::*;
  import dma_burst_pkg::*;

  // descriptor registers
  logic [BusAw-1:0] src_q;
  logic [BusAw-1:0] dst_q;
  logic [BusDw-1:0] num_q;

  // handshake and status state
  logic               ack_q;
  logic               launch_q;
  logic               done_q;
  logic [IdWidth-1:0] id_q;
  logic [BusDw-1:0]   rdata_q;

  reg_addr_e        reg_off;
  logic             acc_start;
  logic             launch_start;
  logic             launch_ack;
  logic [BusDw-1:0] id_word;

  // only the low byte selects a register
  assign reg_off = reg_addr_e'(wb_req_i.adr[7:0]);

  // new access that is not answered yet and has no launch in flight
  assign acc_start = wb_req_i.cyc && wb_req_i.stb && !ack_q && !launch_q;
  // launch is a read of NEXT_ID
  assign launch_start = acc_start && !wb_req_i.we && (reg_off == NEXT_ID);
  // bus ack goes out in the cycle the backend takes the request
  assign launch_ack = launch_q && ready_i;

  // id zero extended to bus width for the launch response
  always_comb begin
    id_word = '0;
    id_word[IdWidth-1:0] = id_q;
  end

  // descriptor towards the backend is held while valid_o is high
  always_comb begin
    burst_o           = '0;
    burst_o.id        = '0;
    burst_o.id[IdWidth-1:0] = id_q;
    burst_o.src       = src_q;
    burst_o.dst       = dst_q;
    burst_o.num_bytes = num_q;
  end

  assign valid_o = launch_q;

  // ordinary accesses ack one cycle after stb and launches when accepted
  assign wb_rsp_o.ack = ack_q || launch_ack;
  assign wb_rsp_o.dat = launch_ack ? id_word : rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      launch_q <= 1'b0;
      done_q   <= 1'b0;
      id_q     <= '0;
    end else begin
      ack_q <= acc_start && !launch_start;
      if (launch_start) begin
        launch_q <= 1'b1;
      end else if (launch_ack) begin
        launch_q <= 1'b0;
      end
      // accepted launch clears done and advances the id modulo 2**IdWidth
      if (launch_ack) begin
        done_q <= 1'b0;
        id_q   <= id_q + 1'b1;
      end else if (complete_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // register writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q <= '0;
      dst_q <= '0;
      num_q <= '0;
    end else if (acc_start && wb_req_i.we) begin
      case (reg_off)
        SRC_ADDR:  src_q <= wb_req_i.dat;
        DST_ADDR:  dst_q <= wb_req_i.dat;
        NUM_BYTES: num_q <= wb_req_i.dat;
        default: ;
      endcase
    end
  end

  // read data is captured at stb and presented with the ack
  always_ff @(posedge clk_i) begin
    if (acc_start && !wb_req_i.we) begin
      case (reg_off)
        SRC_ADDR:  rdata_q <= src_q;
        DST_ADDR:  rdata_q <= dst_q;
        NUM_BYTES: rdata_q <= num_q;
        STATUS:    rdata_q <= {{(BusDw-1){1'b0}}, idle_i};
        DONE:      rdata_q <= {{(BusDw-1){1'b0}}, done_q};
        default:   rdata_q <= '0;
      endcase
    end
  end

endmodule

// ==== verilog/mini_dma_top.sv ====
/*
  Top level of the mini DMA copy engine. Splits the host bus between
  the register frontend and the scratchpad and connects the frontend,
  the copy engine and the scratchpad bank.
*/
`timescale 1ns/100ps

module mini_dma_top #(
  parameter int unsigned SpmWords = 256,
  // at most 8, the width of the id field in the burst request
  parameter int unsigned IdWidth  = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dma_cfg_pkg::wb_req_t host_req_i,
  output dma_cfg_pkg::wb_rsp_t host_rsp_o
);

  import dma_cfg_pkg::*;
  import dma_burst_pkg::*;

  localparam int unsigned Aw = $clog2(SpmWords);

  // per target host requests and responses
  wb_req_t fe_req;
  wb_rsp_t fe_rsp;
  wb_req_t spm_req;
  wb_rsp_t spm_rsp;
  logic    sel_reg;

  // frontend to backend
  burst_req_t burst;
  logic       burst_valid;
  logic       be_ready;
  logic       be_idle;
  logic       be_complete;

  // backend to scratchpad
  logic [Aw-1:0]    spm_addr;
  logic             spm_we;
  logic [BusDw-1:0] spm_wdata;
  logic [BusDw-1:0] spm_rdata;

  // registers at RegBase and above, scratchpad below
  assign sel_reg = (host_req_i.adr >= RegBase);

  // only the selected target sees stb
  always_comb begin
    fe_req      = host_req_i;
    spm_req     = host_req_i;
    fe_req.stb  = host_req_i.stb && sel_reg;
    spm_req.stb = host_req_i.stb && !sel_reg;
  end

  // address is held until ack, so the decode also picks the response
  assign host_rsp_o = sel_reg ? fe_rsp : spm_rsp;

  dma_frontend #(
    .IdWidth(IdWidth)
  ) i_frontend (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wb_req_i  (fe_req),
    .wb_rsp_o  (fe_rsp),
    .burst_o   (burst),
    .valid_o   (burst_valid),
    .ready_i   (be_ready),
    .idle_i    (be_idle),
    .complete_i(be_complete)
  );

  dma_backend #(
    .SpmWords(SpmWords)
  ) i_backend (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .burst_i    (burst),
    .valid_i    (burst_valid),
    .ready_o    (be_ready),
    .idle_o     (be_idle),
    .complete_o (be_complete),
    .spm_addr_o (spm_addr),
    .spm_we_o   (spm_we),
    .spm_wdata_o(spm_wdata),
    .spm_rdata_i(spm_rdata)
  );

  spm_bank #(
    .SpmWords(SpmWords)
  ) i_spm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .host_req_i (spm_req),
    .host_rsp_o (spm_rsp),
    .eng_addr_i (spm_addr),
    .eng_we_i   (spm_we),
    .eng_wdata_i(spm_wdata),
    .eng_rdata_o(spm_rdata)
  );

endmodule

// ==== verilog/spm_bank.sv ====
/*
  Scratchpad word memory with two ports. The host reaches it over
  Wishbone with byte enables, the copy engine over a plain port.
*/
`timescale 1ns/100ps

module spm_bank #(
  parameter int unsigned SpmWords = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  dma_cfg_pkg::wb_req_t          host_req_i,
  output dma_cfg_pkg::wb_rsp_t          host_rsp_o,
  input  logic [$clog2(SpmWords)-1:0]   eng_addr_i,
  input  logic                          eng_we_i,
  input  logic [dma_cfg_pkg::BusDw-1:0] eng_wdata_i,
  output logic [dma_cfg_pkg::BusDw-1:0] eng_rdata_o
);

  import dma_cfg_pkg::*;

  localparam int unsigned Aw = $clog2(SpmWords);

  logic [BusDw-1:0] mem_q [SpmWords];

  logic             ack_q;
  logic [BusDw-1:0] host_rdata_q;
  logic [Aw-1:0]    host_idx;
  logic             host_acc;

  // word index from the byte address
  assign host_idx = host_req_i.adr[2 +: Aw];
  // new host access, the held request is not taken again while acked
  assign host_acc = host_req_i.cyc && host_req_i.stb && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= host_acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_acc) begin
      host_rdata_q <= mem_q[host_idx];
      if (host_req_i.we) begin
        for (int b = 0; b < BusDw / 8; b++) begin
          if (host_req_i.sel[b]) begin
            mem_q[host_idx][8*b +: 8] <= host_req_i.dat[8*b +: 8];
          end
        end
      end
    end
    eng_rdata_o <= mem_q[eng_addr_i];
    // engine write comes last so it wins on a same-word collision
    if (eng_we_i) begin
      mem_q[eng_addr_i] <= eng_wdata_i;
    end
  end

  assign host_rsp_o.ack = ack_q;
  assign host_rsp_o.dat = host_rdata_q;

endmodule
